/* all.f */
verilog/rv_decode_pkg.sv
verilog/alu_dec.sv
verilog/flow_dec.sv
verilog/mem_dec.sv
verilog/sys_dec.sv
verilog/idu.sv
verilog/decode_stage.sv
verification/decode_stage_chk.sv
verification/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
# A $fatal in the model gives a nonzero exit status and stops the script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --timescale 1ns/100ps \
    --top-module decode_stage_tb \
    -f all.f \
    -o decode_stage_tb

./obj_dir/decode_stage_tb

/* verification/decode_stage_chk.sv */
`default_nettype none

module decode_stage_chk import rv_decode_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic inst_valid,
    input dec_s dec,
    input logic dec_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------
    // Strobe timing
    // ----------------------------------------------------------

    // First cycle out of reset has no result yet
    valid_after_reset: assert property (@(posedge clk)
        rst_n && !$past(rst_n) |-> !dec_valid)
        else $error("dec_valid high in the first cycle after reset");

    // One-cycle delay of the input strobe
    valid_follows_strobe: assert property (@(posedge clk)
        $past(rst_n) |-> dec_valid == $past(inst_valid))
        else $error("dec_valid does not follow inst_valid of the previous cycle");

    // ----------------------------------------------------------
    // Result consistency
    // ----------------------------------------------------------

    // Illegal result carries nothing else
    illegal_clears_fields: assert property (@(posedge clk) disable iff (!rst_n)
        dec.illegal |-> {dec.rs1, dec.rs2, dec.rd, dec.imm, dec.csr, dec.opt} == '0)
        else $error("illegal result with nonzero fields");

    // No strobe, no change
    hold_when_idle: assert property (@(posedge clk)
        rst_n && $past(rst_n) && !dec_valid |-> $stable(dec))
        else $error("dec changed without a strobe");

endmodule

`default_nettype wire

/* verification/decode_stage_tb.sv */
`default_nettype none

module decode_stage_tb import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    // Budget per row above the worst case of one strobe and three idle cycles
    localparam int ROW_CYCLES   = 5;

    typedef logic [$bits(dec_s)-1:0] word_t;

    // One stimulus word and its expected decode
    typedef struct packed {
        logic [31:0] word;
        dec_s        exp;
    } row_s;

    logic  clk;
    logic  rst_n;
    inst_u inst;
    logic  inst_valid;
    dec_s  dec;
    logic  dec_valid;

    row_s        rows[$];
    logic [31:0] lfsr_state = 32'hbf4c_b579;

    decode_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dec_valid  (dec_valid)
    );

    bind decode_stage decode_stage_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dec_valid  (dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("mismatch at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Every field by name plus the strobe
    task automatic check_output(input logic valid_exp, input dec_s exp);
        compare("dec_valid", word_t'(valid_exp), word_t'(dec_valid));
        compare("illegal", word_t'(exp.illegal), word_t'(dec.illegal));
        compare("rs1", word_t'(exp.rs1), word_t'(dec.rs1));
        compare("rs2", word_t'(exp.rs2), word_t'(dec.rs2));
        compare("rd", word_t'(exp.rd), word_t'(dec.rd));
        compare("imm", word_t'(exp.imm), word_t'(dec.imm));
        compare("csr", word_t'(exp.csr), word_t'(dec.csr));
        compare("opt", word_t'(exp.opt), word_t'(dec.opt));
    endtask

    // Args are word, opt, rd, rs1, rs2, imm, csr
    task automatic add_row(input logic [31:0] word, input opt_e opt, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm, input logic [11:0] csr);
        row_s r;
        r.word    = word;
        r.exp     = '0;
        r.exp.opt = opt;
        r.exp.rd  = rd;
        r.exp.rs1 = rs1;
        r.exp.rs2 = rs2;
        r.exp.imm = imm;
        r.exp.csr = csr;
        rows.push_back(r);
    endtask

    task automatic add_illegal(input logic [31:0] word);
        row_s r;
        r.word        = word;
        r.exp         = '0;
        r.exp.illegal = 1'b1;
        rows.push_back(r);
    endtask

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    task automatic fill_table();
        // All ten OP forms
        add_row(32'h003100b3, OPT_ADD,   5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h407302b3, OPT_SUB,   5'd5,  5'd6,  5'd7,  32'h0, 12'h0);
        add_row(32'h00c59533, OPT_SLL,   5'd10, 5'd11, 5'd12, 32'h0, 12'h0);
        add_row(32'h003120b3, OPT_SLT,   5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h003130b3, OPT_SLTU,  5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h003140b3, OPT_XOR,   5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h003150b3, OPT_SRL,   5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h403150b3, OPT_SRA,   5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h003160b3, OPT_OR,    5'd1,  5'd2,  5'd3,  32'h0, 12'h0);
        add_row(32'h01df7fb3, OPT_AND,   5'd31, 5'd30, 5'd29, 32'h0, 12'h0);
        // OP-IMM with edge immediates and shamt
        add_row(32'hfff10093, OPT_ADDI,  5'd1,  5'd2,  5'd0, 32'hffff_ffff, 12'h0);
        add_row(32'h7ff20193, OPT_ADDI,  5'd3,  5'd4,  5'd0, 32'h0000_07ff, 12'h0);
        add_row(32'h80032293, OPT_SLTI,  5'd5,  5'd6,  5'd0, 32'hffff_f800, 12'h0);
        add_row(32'h00543393, OPT_SLTIU, 5'd7,  5'd8,  5'd0, 32'h0000_0005, 12'h0);
        add_row(32'hf0054493, OPT_XORI,  5'd9,  5'd10, 5'd0, 32'hffff_ff00, 12'h0);
        add_row(32'h12366593, OPT_ORI,   5'd11, 5'd12, 5'd0, 32'h0000_0123, 12'h0);
        add_row(32'h0ff77693, OPT_ANDI,  5'd13, 5'd14, 5'd0, 32'h0000_00ff, 12'h0);
        add_row(32'h01f11093, OPT_SLLI,  5'd1,  5'd2,  5'd0, 32'h0000_001f, 12'h0);
        add_row(32'h00725193, OPT_SRLI,  5'd3,  5'd4,  5'd0, 32'h0000_0007, 12'h0);
        add_row(32'h41f35293, OPT_SRAI,  5'd5,  5'd6,  5'd0, 32'h0000_001f, 12'h0);
        // Control flow with the sign bit both ways
        add_row(32'hffdff0ef, OPT_JAL,   5'd1,  5'd0,  5'd0, 32'hffff_fffc, 12'h0);
        add_row(32'h344122ef, OPT_JAL,   5'd5,  5'd0,  5'd0, 32'h0001_2344, 12'h0);
        add_row(32'hff8280e7, OPT_JALR,  5'd1,  5'd5,  5'd0, 32'hffff_fff8, 12'h0);
        add_row(32'h00208863, OPT_BEQ,   5'd0,  5'd1,  5'd2, 32'h0000_0010, 12'h0);
        add_row(32'hfe419fe3, OPT_BNE,   5'd0,  5'd3,  5'd4, 32'hffff_fffe, 12'h0);
        add_row(32'h0062c0e3, OPT_BLT,   5'd0,  5'd5,  5'd6, 32'h0000_0800, 12'h0);
        add_row(32'h0020d863, OPT_BGE,   5'd0,  5'd1,  5'd2, 32'h0000_0010, 12'h0);
        add_row(32'h0020e863, OPT_BLTU,  5'd0,  5'd1,  5'd2, 32'h0000_0010, 12'h0);
        add_row(32'h0020f863, OPT_BGEU,  5'd0,  5'd1,  5'd2, 32'h0000_0010, 12'h0);
        add_row(32'h80000537, OPT_LUI,   5'd10, 5'd0,  5'd0, 32'h8000_0000, 12'h0);
        add_row(32'h12345137, OPT_LUI,   5'd2,  5'd0,  5'd0, 32'h1234_5000, 12'h0);
        add_row(32'hfffff197, OPT_AUIPC, 5'd3,  5'd0,  5'd0, 32'hffff_f000, 12'h0);
        add_row(32'h00001217, OPT_AUIPC, 5'd4,  5'd0,  5'd0, 32'h0000_1000, 12'h0);
        // Loads, stores, fences
        add_row(32'hfff10083, OPT_LB,    5'd1,  5'd2,  5'd0, 32'hffff_ffff, 12'h0);
        add_row(32'h00421183, OPT_LH,    5'd3,  5'd4,  5'd0, 32'h0000_0004, 12'h0);
        add_row(32'h7ff32283, OPT_LW,    5'd5,  5'd6,  5'd0, 32'h0000_07ff, 12'h0);
        add_row(32'h00044383, OPT_LBU,   5'd7,  5'd8,  5'd0, 32'h0000_0000, 12'h0);
        add_row(32'h80055483, OPT_LHU,   5'd9,  5'd10, 5'd0, 32'hffff_f800, 12'h0);
        add_row(32'hfe208fa3, OPT_SB,    5'd0,  5'd1,  5'd2, 32'hffff_ffff, 12'h0);
        add_row(32'h00321423, OPT_SH,    5'd0,  5'd4,  5'd3, 32'h0000_0008, 12'h0);
        add_row(32'h7e532223, OPT_SW,    5'd0,  5'd6,  5'd5, 32'h0000_07e4, 12'h0);
        add_row(32'h0ff0000f, OPT_FENCE, 5'd0,  5'd0,  5'd0, 32'h0, 12'h0);
        add_row(32'h0000100f, OPT_FENCE_I, 5'd0, 5'd0, 5'd0, 32'h0, 12'h0);
        // System and CSR forms
        add_row(32'h00000073, OPT_ECALL,  5'd0, 5'd0, 5'd0, 32'h0, 12'h000);
        add_row(32'h00100073, OPT_EBREAK, 5'd0, 5'd0, 5'd0, 32'h0, 12'h000);
        add_row(32'h30200073, OPT_MRET,   5'd0, 5'd0, 5'd0, 32'h0, 12'h000);
        add_row(32'h300110f3, OPT_CSRRW,  5'd1, 5'd2, 5'd0, 32'h0, 12'h300);
        add_row(32'hc00021f3, OPT_CSRRS,  5'd3, 5'd0, 5'd0, 32'h0, 12'hc00);
        add_row(32'h3412b273, OPT_CSRRC,  5'd4, 5'd5, 5'd0, 32'h0, 12'h341);
        add_row(32'h305fd373, OPT_CSRRWI, 5'd6, 5'd0, 5'd0, 32'h0000_001f, 12'h305);
        add_row(32'h3440e3f3, OPT_CSRRSI, 5'd7, 5'd0, 5'd0, 32'h0000_0001, 12'h344);
        add_row(32'hfff57073, OPT_CSRRCI, 5'd0, 5'd0, 5'd0, 32'h0000_000a, 12'hfff);
        // Illegal encodings
        add_illegal(32'h0000005b);
        add_illegal(32'h003100b2);
        add_illegal(32'h0020a863);
        add_illegal(32'h00423183);
        add_illegal(32'h00323423);
        add_illegal(32'h300140f3);
        add_illegal(32'h023100b3);
        add_illegal(32'hff8290e7);
        add_illegal(32'h41f11093);
        add_illegal(32'h000000f3);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int gap;
        int limit_ns;
        rst_n      = 1'b0;
        inst       = 32'h003100b3;
        // Strobe held during reset must be ignored
        inst_valid = 1'b1;
        fill_table();
        limit_ns = (rows.size() * ROW_CYCLES + RESET_CYCLES) * CLK_PERIOD;
        fork
            begin
                #(limit_ns);
                $display("timeout: run still busy after %0d ns", limit_ns);
                abort_run();
            end
        join_none
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_output(1'b0, '0);
        end
        rst_n      = 1'b1;
        inst_valid = 1'b0;
        foreach (rows[i]) begin
            inst       = rows[i].word;
            inst_valid = 1'b1;
            @(negedge clk);
            check_output(1'b1, rows[i].exp);
            inst_valid = 1'b0;
            // Zero gap means back-to-back strobes
            gap = int'(take_bits(2));
            repeat (gap) begin
                // Junk on the bus while the result holds
                inst = take_bits(32);
                @(negedge clk);
                check_output(1'b0, rows[i].exp);
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu_dec.sv */
`default_nettype none

module alu_dec import rv_decode_pkg::*; (
    input  inst_u inst,
    output logic  hit,
    output dec_s  dec
);

    logic       is_op;
    logic       is_imm;
    logic       bad;
    logic [2:0] f3;
    logic [6:0] f7;

    assign f3     = inst.r_fmt.funct3;
    assign f7     = inst.r_fmt.funct7;
    assign is_op  = inst.r_fmt.opcode == OPC_OP;
    assign is_imm = inst.i_fmt.opcode == OPC_OP_IMM;
    assign hit    = is_op | is_imm;

    always_comb begin
        dec = '0;
        bad = 1'b0;
        if (is_op) begin
            dec.rs1 = inst.r_fmt.rs1;
            dec.rs2 = inst.r_fmt.rs2;
            dec.rd  = inst.r_fmt.rd;
            // Alternate funct7 only for SUB and SRA
            if (f7 == 7'h20) begin
                bad = (f3 != 3'd0) && (f3 != 3'd5);
            end else begin
                bad = f7 != 7'h00;
            end
            case (f3)
                3'd0:    dec.opt = f7[5] ? OPT_SUB : OPT_ADD;
                3'd1:    dec.opt = OPT_SLL;
                3'd2:    dec.opt = OPT_SLT;
                3'd3:    dec.opt = OPT_SLTU;
                3'd4:    dec.opt = OPT_XOR;
                3'd5:    dec.opt = f7[5] ? OPT_SRA : OPT_SRL;
                3'd6:    dec.opt = OPT_OR;
                default: dec.opt = OPT_AND;
            endcase
        end else if (is_imm) begin
            dec.rs1 = inst.i_fmt.rs1;
            dec.rd  = inst.i_fmt.rd;
            // Sign-extended I immediate
            dec.imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            case (f3)
                3'd0: dec.opt = OPT_ADDI;
                3'd2: dec.opt = OPT_SLTI;
                3'd3: dec.opt = OPT_SLTIU;
                3'd4: dec.opt = OPT_XORI;
                3'd6: dec.opt = OPT_ORI;
                3'd7: dec.opt = OPT_ANDI;
                3'd1: begin
                    // Shamt sits in the rs2 slot
                    dec.opt = OPT_SLLI;
                    dec.imm = {27'd0, inst.r_fmt.rs2};
                    bad     = f7 != 7'h00;
                end
                default: begin
                    dec.opt = f7[5] ? OPT_SRAI : OPT_SRLI;
                    dec.imm = {27'd0, inst.r_fmt.rs2};
                    bad     = (f7 != 7'h00) && (f7 != 7'h20);
                end
            endcase
        end
        // Bad encoding wipes every field
        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage import rv_decode_pkg::*; #(
    parameter bit EN_ZICSR = 1'b1
) (
    input  logic  clk,
    input  logic  rst_n,
    input  inst_u inst,
    input  logic  inst_valid,
    output dec_s  dec,
    output logic  dec_valid
);

    // Combinational decode of the incoming word
    dec_s idu_dec;

    idu #(
        .EN_ZICSR (EN_ZICSR)
    ) u_idu (
        .inst (inst),
        .dec  (idu_dec)
    );

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            // Strobe delayed by one edge
            dec_valid <= inst_valid;
            // Result held between strobes
            if (inst_valid) begin
                dec <= idu_dec;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/flow_dec.sv */
`default_nettype none

module flow_dec import rv_decode_pkg::*; (
    input  inst_u inst,
    output logic  hit,
    output dec_s  dec
);

    logic bad;

    always_comb begin
        dec = '0;
        hit = 1'b0;
        bad = 1'b0;
        case (inst.r_fmt.opcode)
            OPC_JAL: begin
                hit     = 1'b1;
                dec.opt = OPT_JAL;
                dec.rd  = inst.j_fmt.rd;
                // J immediate, bit 0 always zero
                dec.imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                           inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                           inst.j_fmt.imm_10_1, 1'b0};
            end
            OPC_JALR: begin
                hit     = 1'b1;
                dec.opt = OPT_JALR;
                dec.rd  = inst.i_fmt.rd;
                dec.rs1 = inst.i_fmt.rs1;
                dec.imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
                bad     = inst.i_fmt.funct3 != 3'd0;
            end
            OPC_BRANCH: begin
                hit     = 1'b1;
                dec.rs1 = inst.b_fmt.rs1;
                dec.rs2 = inst.b_fmt.rs2;
                // B immediate, bit 11 comes from the rd slot
                dec.imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12,
                           inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                           inst.b_fmt.imm_4_1, 1'b0};
                case (inst.b_fmt.funct3)
                    3'd0:    dec.opt = OPT_BEQ;
                    3'd1:    dec.opt = OPT_BNE;
                    3'd4:    dec.opt = OPT_BLT;
                    3'd5:    dec.opt = OPT_BGE;
                    3'd6:    dec.opt = OPT_BLTU;
                    3'd7:    dec.opt = OPT_BGEU;
                    // Funct3 2 and 3 unassigned
                    default: bad = 1'b1;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                hit     = 1'b1;
                // Bit 5 of the opcode tells LUI from AUIPC
                dec.opt = inst.u_fmt.opcode[5] ? OPT_LUI : OPT_AUIPC;
                dec.rd  = inst.u_fmt.rd;
                dec.imm = {inst.u_fmt.imm_31_12, 12'd0};
            end
            default: begin
                hit = 1'b0;
            end
        endcase
        // Keep hit, clear the rest
        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/idu.sv */
`default_nettype none

module idu import rv_decode_pkg::*; #(
    parameter bit EN_ZICSR = 1'b1
) (
    input  inst_u inst,
    output dec_s  dec
);

    // Group order in the hit vector
    localparam int GRP_ALU  = 0;
    localparam int GRP_FLOW = 1;
    localparam int GRP_MEM  = 2;
    localparam int GRP_SYS  = 3;
    localparam int NUM_GRP  = 4;

    logic [NUM_GRP-1:0] grp_hit;
    dec_s               grp_dec [NUM_GRP];

    // ----------------------------------------------------------
    // Group decoders see the same word
    // ----------------------------------------------------------
    alu_dec u_alu_dec (
        .inst (inst),
        .hit  (grp_hit[GRP_ALU]),
        .dec  (grp_dec[GRP_ALU])
    );

    flow_dec u_flow_dec (
        .inst (inst),
        .hit  (grp_hit[GRP_FLOW]),
        .dec  (grp_dec[GRP_FLOW])
    );

    mem_dec u_mem_dec (
        .inst (inst),
        .hit  (grp_hit[GRP_MEM]),
        .dec  (grp_dec[GRP_MEM])
    );

    sys_dec #(
        .EN_ZICSR (EN_ZICSR)
    ) u_sys_dec (
        .inst (inst),
        .hit  (grp_hit[GRP_SYS]),
        .dec  (grp_dec[GRP_SYS])
    );

    // ----------------------------------------------------------
    // Merge by hit flag
    // ----------------------------------------------------------
    always_comb begin
        dec = '0;
        // One-hot hits select at most one result
        for (int i = 0; i < NUM_GRP; i++) begin
            if (grp_hit[i]) begin
                dec = grp_dec[i];
            end
        end
        // Unclaimed opcodes include every word without 2'b11 low bits
        if (grp_hit == '0) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_dec.sv */
`default_nettype none

module mem_dec import rv_decode_pkg::*; (
    input  inst_u inst,
    output logic  hit,
    output dec_s  dec
);

    logic bad;

    always_comb begin
        dec = '0;
        hit = 1'b0;
        bad = 1'b0;
        case (inst.r_fmt.opcode)
            OPC_LOAD: begin
                hit     = 1'b1;
                dec.rd  = inst.i_fmt.rd;
                dec.rs1 = inst.i_fmt.rs1;
                dec.imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
                case (inst.i_fmt.funct3)
                    3'd0:    dec.opt = OPT_LB;
                    3'd1:    dec.opt = OPT_LH;
                    3'd2:    dec.opt = OPT_LW;
                    3'd4:    dec.opt = OPT_LBU;
                    3'd5:    dec.opt = OPT_LHU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                hit     = 1'b1;
                dec.rs1 = inst.s_fmt.rs1;
                dec.rs2 = inst.s_fmt.rs2;
                // S immediate rejoined from both halves
                dec.imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                           inst.s_fmt.imm_4_0};
                case (inst.s_fmt.funct3)
                    3'd0:    dec.opt = OPT_SB;
                    3'd1:    dec.opt = OPT_SH;
                    3'd2:    dec.opt = OPT_SW;
                    default: bad = 1'b1;
                endcase
            end
            OPC_MISC_MEM: begin
                hit    = 1'b1;
                // Fence carries rd only, no immediate
                dec.rd = inst.i_fmt.rd;
                case (inst.i_fmt.funct3)
                    3'd0:    dec.opt = OPT_FENCE;
                    3'd1:    dec.opt = OPT_FENCE_I;
                    default: bad = 1'b1;
                endcase
            end
            default: begin
                hit = 1'b0;
            end
        endcase
        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // ----------------------------------------------------------
    // Instruction format views
    // ----------------------------------------------------------

    // Register-register
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    // Register-immediate, loads, JALR, SYSTEM
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    // Stores, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    // Branches, bit 11 parked where S puts bit 0
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_s;

    // LUI and AUIPC
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    // JAL
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    // One word, six readings
    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        s_fmt_s s_fmt;
        b_fmt_s b_fmt;
        u_fmt_s u_fmt;
        j_fmt_s j_fmt;
    } inst_u;

    // ----------------------------------------------------------
    // Operations
    // ----------------------------------------------------------

    // Zero doubles as the illegal marker
    typedef enum logic [5:0] {
        OPT_NONE = 6'd0,
        OPT_ADD, OPT_SUB, OPT_SLL, OPT_SLT, OPT_SLTU,
        OPT_XOR, OPT_SRL, OPT_SRA, OPT_OR, OPT_AND,
        OPT_ADDI, OPT_SLTI, OPT_SLTIU, OPT_XORI, OPT_ORI,
        OPT_ANDI, OPT_SLLI, OPT_SRLI, OPT_SRAI,
        OPT_LB, OPT_LH, OPT_LW, OPT_LBU, OPT_LHU,
        OPT_SB, OPT_SH, OPT_SW,
        OPT_BEQ, OPT_BNE, OPT_BLT, OPT_BGE, OPT_BLTU, OPT_BGEU,
        OPT_JAL, OPT_JALR, OPT_LUI, OPT_AUIPC,
        OPT_FENCE, OPT_FENCE_I,
        OPT_ECALL, OPT_EBREAK, OPT_MRET,
        OPT_CSRRW, OPT_CSRRS, OPT_CSRRC,
        OPT_CSRRWI, OPT_CSRRSI, OPT_CSRRCI
    } opt_e;

    // Decode result, 66 bits
    typedef struct packed {
        logic        illegal;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [11:0] csr;
        opt_e        opt;
    } dec_s;

    // ----------------------------------------------------------
    // Major opcodes
    // ----------------------------------------------------------
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage

`default_nettype wire

/* verilog/sys_dec.sv */
`default_nettype none

module sys_dec import rv_decode_pkg::*; #(
    parameter bit EN_ZICSR = 1'b1
) (
    input  inst_u inst,
    output logic  hit,
    output dec_s  dec
);

    logic        bad;
    logic [2:0]  f3;
    logic [11:0] f12;

    assign f3  = inst.i_fmt.funct3;
    assign f12 = inst.i_fmt.imm_11_0;
    assign hit = inst.i_fmt.opcode == OPC_SYSTEM;

    always_comb begin
        dec = '0;
        bad = 1'b0;
        if (hit) begin
            if (f3 == 3'd0) begin
                // Privileged group, no operands allowed
                bad = (inst.i_fmt.rs1 != 5'd0) || (inst.i_fmt.rd != 5'd0);
                case (f12)
                    12'h000: dec.opt = OPT_ECALL;
                    12'h001: dec.opt = OPT_EBREAK;
                    12'h302: dec.opt = OPT_MRET;
                    default: bad = 1'b1;
                endcase
            end else if (!EN_ZICSR || f3 == 3'd4) begin
                // No CSR support, or reserved funct3
                bad = 1'b1;
            end else begin
                dec.csr = f12;
                dec.rd  = inst.i_fmt.rd;
                case (f3)
                    3'd1: dec.opt = OPT_CSRRW;
                    3'd2: dec.opt = OPT_CSRRS;
                    3'd3: dec.opt = OPT_CSRRC;
                    3'd5: dec.opt = OPT_CSRRWI;
                    3'd6: dec.opt = OPT_CSRRSI;
                    default: dec.opt = OPT_CSRRCI;
                endcase
                // Funct3 bit 2 picks zimm over rs1
                if (f3[2]) begin
                    dec.imm = {27'd0, inst.i_fmt.rs1};
                end else begin
                    dec.rs1 = inst.i_fmt.rs1;
                end
            end
        end
        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire
